/* source/vgc_pkg.sv */
package vgc_pkg;

    // Vector types with a fixed meaning in the SHR datapath
    typedef logic [9:0]  hcount_t;   // Horizontal slot count
    typedef logic [8:0]  vcount_t;   // Line number
    typedef logic [22:0] vaddr_t;    // Video memory byte address
    typedef logic [7:0]  byte_t;     // SCB, palette or pixel byte
    typedef logic [3:0]  pal_idx_t;  // Palette entry number
    typedef logic [3:0]  nibble_t;   // One colour channel level
    typedef logic [11:0] rgb12_t;    // {red, green, blue}

    // Line timing in pixel slots
    localparam hcount_t H_TOTAL        = 10'd912;  // Slots 0 to 911
    localparam hcount_t H_ACTIVE_START = 10'd32;   // First window column
    localparam hcount_t H_ACTIVE_COLS  = 10'd640;
    localparam hcount_t H_SCB_ADDR     = 10'd900;  // SCB address goes out here

    // Frame timing in lines
    localparam vcount_t V_ACTIVE_START = 9'd16;
    localparam vcount_t V_ACTIVE_LINES = 9'd200;
    localparam vcount_t V_VBL_LINE     = 9'd216;

    // SHR memory map, linear layout
    localparam int     PAL_BYTES      = 32;        // 16 entries of two bytes
    localparam vaddr_t SHR_PIXEL_BASE = 23'h12000;
    localparam int     SHR_ROW_BYTES  = 160;
    localparam vaddr_t SHR_SCB_BASE   = 23'h19D00;
    localparam vaddr_t SHR_PAL_BASE   = 23'h19E00;
    localparam int     SHR_PAL_STRIDE = 32;

    // SCB bit positions, low nibble is the palette number
    localparam int SCB_BIT_640  = 7;
    localparam int SCB_BIT_IRQ  = 6;
    localparam int SCB_BIT_FILL = 5;

    // Where the fetch engine is within a line
    typedef enum logic [1:0] {
        PH_IDLE,
        PH_SCB,
        PH_PALETTE,
        PH_PIXELS
    } fetch_phase_t;

    // Fixed IIgs colours used for the border
    localparam rgb12_t BORDER_PALETTE [16] = '{
        12'h000, 12'hd03, 12'h009, 12'hd2d,  // Black, deep red, dark blue, purple
        12'h072, 12'h555, 12'h22f, 12'h6af,  // Dark green, dark grey, blues
        12'h850, 12'hf60, 12'haaa, 12'hf98,  // Brown, orange, light grey, pink
        12'h1d0, 12'hff0, 12'h4f9, 12'hfff   // Light green, yellow, aqua, white
    };

endpackage

/* source/shr_fetch.sv */
`timescale 1ns/1ps

module shr_fetch (
    input  logic             clk_vid,
    input  logic             reset,
    input  logic             ce_pix,
    input  vgc_pkg::hcount_t h_count,
    input  vgc_pkg::vcount_t v_count,
    input  vgc_pkg::byte_t   video_data,
    input  logic             shr_enable,
    output vgc_pkg::vaddr_t  video_addr,
    output vgc_pkg::byte_t   scb,
    output logic             pal_load,
    output logic             scanline_irq
);
    import vgc_pkg::*;

    // Slot map of one line
    localparam hcount_t H_SCB_SAMPLE  = H_SCB_ADDR + 10'd1;       // SCB byte arrives
    localparam hcount_t H_PAL_LAST    = hcount_t'(H_SCB_ADDR + 1 + PAL_BYTES - H_TOTAL);
    localparam hcount_t H_PIX_BASE    = H_ACTIVE_START - 10'd1;   // Pixel base goes out
    localparam hcount_t H_ACTIVE_LAST = H_ACTIVE_START + H_ACTIVE_COLS - 10'd1;

    fetch_phase_t phase;
    vcount_t      scb_row;      // Row shown on the next line
    vcount_t      pix_row;      // Row shown on this line
    logic         line_active;  // This line is inside the 200 SHR rows
    logic         irq_req;

    // Rows wrap in 9 bits, lines above the window give large values
    assign scb_row = v_count + 9'd1 - V_ACTIVE_START;
    assign pix_row = v_count - V_ACTIVE_START;

    assign line_active = (v_count >= V_ACTIVE_START) &&
                         (v_count < V_ACTIVE_START + V_ACTIVE_LINES);

    // Interrupt request from the SCB on the bus in the sample slot
    assign irq_req = video_data[SCB_BIT_IRQ] && shr_enable && (scb_row < V_ACTIVE_LINES);

    // Palette bytes are on the bus for the whole palette phase
    assign pal_load = (phase == PH_PALETTE);

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            phase        <= PH_IDLE;
            video_addr   <= '0;
            scb          <= '0;
            scanline_irq <= 1'b0;
        end else if (ce_pix) begin
            scanline_irq <= 1'b0;  // Pulse lasts one slot
            case (h_count)
                H_SCB_ADDR: begin
                    phase      <= PH_SCB;
                    video_addr <= SHR_SCB_BASE + vaddr_t'(scb_row);
                end
                H_SCB_SAMPLE: begin
                    // Latch SCB, point at the palette it selects
                    phase        <= PH_PALETTE;
                    scb          <= video_data;
                    scanline_irq <= irq_req;
                    video_addr   <= SHR_PAL_BASE +
                                    vaddr_t'(video_data[3:0]) * vaddr_t'(SHR_PAL_STRIDE);
                end
                H_PIX_BASE: begin
                    if (line_active) begin
                        phase      <= PH_PIXELS;
                        video_addr <= SHR_PIXEL_BASE +
                                      vaddr_t'(pix_row) * vaddr_t'(SHR_ROW_BYTES);
                    end else begin
                        phase <= PH_IDLE;  // No pixel fetch on border lines
                    end
                end
                default: begin
                    if (phase == PH_PALETTE) begin
                        video_addr <= video_addr + 23'd1;  // One palette byte per slot
                        if (h_count == H_PAL_LAST) begin
                            phase <= PH_IDLE;
                        end
                    end else if (phase == PH_PIXELS) begin
                        // Next byte after the fourth slot of the current one
                        if (h_count[1:0] == 2'b11) begin
                            video_addr <= video_addr + 23'd1;
                        end
                        if (h_count == H_ACTIVE_LAST) begin
                            phase <= PH_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // Palette and pixel fetches never leave bank $01
    a_addr_in_bank: assert property (@(posedge clk_vid) disable iff (reset)
        (phase inside {PH_PALETTE, PH_PIXELS}) |-> (video_addr < 23'h20000));

endmodule

/* source/shr_palette.sv */
`timescale 1ns/1ps

module shr_palette (
    input  logic              clk_vid,
    input  logic              reset,
    input  logic              ce_pix,
    input  logic              pal_load,
    input  vgc_pkg::byte_t    video_data,
    input  vgc_pkg::pal_idx_t rd_idx,
    output vgc_pkg::rgb12_t   rd_rgb
);
    import vgc_pkg::*;

    localparam int CNT_W = $clog2(PAL_BYTES);

    rgb12_t           entry [16];  // Current row palette
    logic [CNT_W-1:0] byte_cnt;    // Next byte number within the load burst
    logic [CNT_W-1:0] wr_cnt;      // Byte number used in this slot
    logic             load_d;      // pal_load of the previous slot
    pal_idx_t         wr_idx;

    // A new burst starts at byte 0
    assign wr_cnt = load_d ? byte_cnt : '0;
    assign wr_idx = wr_cnt[CNT_W-1:1];  // Two bytes per entry

    assign rd_rgb = entry[rd_idx];

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            byte_cnt <= '0;
            load_d   <= 1'b0;
        end else if (ce_pix) begin
            load_d <= pal_load;
            if (pal_load) begin
                byte_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_vid) begin
        if (ce_pix && pal_load) begin
            if (!wr_cnt[0]) begin
                entry[wr_idx][7:0] <= video_data;  // Green high, blue low
            end else begin
                entry[wr_idx][11:8] <= video_data[3:0];  // Red, high nibble unused
            end
        end
    end

    // A burst longer than 32 bytes would wrap onto entry 0
    a_pal_no_wrap: assert property (@(posedge clk_vid) disable iff (reset)
        (ce_pix && pal_load && load_d) |-> (byte_cnt != '0));

endmodule

/* source/shr_pixel_decode.sv */
`timescale 1ns/1ps

module shr_pixel_decode (
    input  logic              clk_vid,
    input  logic              reset,
    input  logic              ce_pix,
    input  vgc_pkg::hcount_t  h_count,
    input  vgc_pkg::byte_t    video_data,
    input  vgc_pkg::byte_t    scb,
    output vgc_pkg::pal_idx_t pix_idx
);
    import vgc_pkg::*;

    logic       active;     // Slot is inside the 640 columns
    logic [1:0] byte_slot;  // Which of the four slots of a byte
    nibble_t    nib;        // 320 mode pixel for this slot
    pal_idx_t   last_nz;    // Last nonzero 320 pixel on this line
    pal_idx_t   fill_prev;
    pal_idx_t   idx_640;
    pal_idx_t   idx_320;

    assign active = (h_count >= H_ACTIVE_START) &&
                    (h_count < H_ACTIVE_START + H_ACTIVE_COLS);

    assign byte_slot = h_count[1:0] - H_ACTIVE_START[1:0];

    // 640 mode, each 2-bit pixel uses its own sub-palette
    always_comb begin
        case (byte_slot)
            2'd0:    idx_640 = {2'd2, video_data[7:6]};
            2'd1:    idx_640 = {2'd3, video_data[5:4]};
            2'd2:    idx_640 = {2'd0, video_data[3:2]};
            default: idx_640 = {2'd1, video_data[1:0]};
        endcase
    end

    // 320 mode, each nibble covers two slots
    assign nib = byte_slot[1] ? video_data[3:0] : video_data[7:4];

    // Fill history restarts at the left edge
    assign fill_prev = (h_count == H_ACTIVE_START) ? '0 : last_nz;

    assign idx_320 = (scb[SCB_BIT_FILL] && (nib == 4'd0)) ? fill_prev : nib;

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            pix_idx <= '0;
            last_nz <= '0;
        end else if (ce_pix && active) begin
            pix_idx <= scb[SCB_BIT_640] ? idx_640 : idx_320;
            if (nib != 4'd0) begin
                last_nz <= nib;
            end else begin
                last_nz <= fill_prev;  // Holds the value, or clears at the left edge
            end
        end
    end

endmodule

/* source/vid_output.sv */
`timescale 1ns/1ps

module vid_output (
    input  logic              clk_vid,
    input  logic              reset,
    input  logic              ce_pix,
    input  vgc_pkg::hcount_t  h_count,
    input  vgc_pkg::vcount_t  v_count,
    input  logic              shr_enable,
    input  vgc_pkg::pal_idx_t border_color,
    input  vgc_pkg::rgb12_t   pix_rgb,
    output vgc_pkg::byte_t    r,
    output vgc_pkg::byte_t    g,
    output vgc_pkg::byte_t    b,
    output logic              vbl_irq
);
    import vgc_pkg::*;

    logic    h_in;       // Column inside 32..671
    logic    v_in;       // Line inside 16..215
    logic    in_window;
    logic    win_d;      // Window flag aligned with pix_idx
    rgb12_t  out_rgb;
    nibble_t red;
    nibble_t grn;
    nibble_t blu;

    assign h_in = (h_count >= H_ACTIVE_START) &&
                  (h_count < H_ACTIVE_START + H_ACTIVE_COLS);
    assign v_in = (v_count >= V_ACTIVE_START) &&
                  (v_count < V_ACTIVE_START + V_ACTIVE_LINES);

    // SHR off shows border over the whole screen
    assign in_window = shr_enable && h_in && v_in;

    assign out_rgb = win_d ? pix_rgb : BORDER_PALETTE[border_color];

    assign red = out_rgb[11:8];
    assign grn = out_rgb[7:4];
    assign blu = out_rgb[3:0];

    always_ff @(posedge clk_vid) begin
        if (reset) begin
            win_d   <= 1'b0;
            r       <= '0;
            g       <= '0;
            b       <= '0;
            vbl_irq <= 1'b0;
        end else if (ce_pix) begin
            win_d <= in_window;
            // Nibble doubling spreads 0..F over the full 8-bit range
            r <= {red, red};
            g <= {grn, grn};
            b <= {blu, blu};
            vbl_irq <= (v_count == V_VBL_LINE);  // Level for the whole line
        end
    end

endmodule

/* source/vgc_top.sv */
`timescale 1ns/1ps

module vgc_top (
    input  logic              clk_vid,
    input  logic              reset,
    input  logic              ce_pix,
    input  vgc_pkg::hcount_t  h_count,
    input  vgc_pkg::vcount_t  v_count,
    input  vgc_pkg::byte_t    video_data,
    input  logic              shr_enable,
    input  vgc_pkg::pal_idx_t border_color,
    output vgc_pkg::vaddr_t   video_addr,
    output vgc_pkg::byte_t    r,
    output vgc_pkg::byte_t    g,
    output vgc_pkg::byte_t    b,
    output logic              scanline_irq,
    output logic              vbl_irq
);
    import vgc_pkg::*;

    byte_t    scb;       // SCB of the row on screen
    logic     pal_load;
    pal_idx_t pix_idx;   // Decoded pixel, one slot after the data
    rgb12_t   pix_rgb;   // Palette colour of pix_idx

    // Address generation, SCB latch and scanline interrupt
    shr_fetch i_fetch (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_count      (h_count),
        .v_count      (v_count),
        .video_data   (video_data),
        .shr_enable   (shr_enable),
        .video_addr   (video_addr),
        .scb          (scb),
        .pal_load     (pal_load),
        .scanline_irq (scanline_irq)
    );

    shr_palette i_palette (
        .clk_vid    (clk_vid),
        .reset      (reset),
        .ce_pix     (ce_pix),
        .pal_load   (pal_load),
        .video_data (video_data),
        .rd_idx     (pix_idx),
        .rd_rgb     (pix_rgb)
    );

    shr_pixel_decode i_decode (
        .clk_vid    (clk_vid),
        .reset      (reset),
        .ce_pix     (ce_pix),
        .h_count    (h_count),
        .video_data (video_data),
        .scb        (scb),
        .pix_idx    (pix_idx)
    );

    // Border mux and RGB register
    vid_output i_output (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_count      (h_count),
        .v_count      (v_count),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .pix_rgb      (pix_rgb),
        .r            (r),
        .g            (g),
        .b            (b),
        .vbl_irq      (vbl_irq)
    );

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk_vid,
    output logic reset
);
    // 4 ns period, first rising edge at 2 ns
    initial begin
        clk_vid = 1'b0;
        forever #2 clk_vid = ~clk_vid;
    end

    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clk_vid);  // Two cycles of reset
        reset <= 1'b0;
    end

endmodule

/* test/tb_vgc.sv */
`timescale 1ns/1ps

module tb_vgc;
    import vgc_pkg::*;

    localparam int TEST_LINES = 15;  // Lines run by all tests together
    localparam int MAX_CYCLES = TEST_LINES * int'(H_TOTAL) + 1000;
    localparam int COL_FIRST  = int'(H_ACTIVE_START);
    localparam int COL_END    = COL_FIRST + int'(H_ACTIVE_COLS);

    logic     clk_vid;
    logic     reset;
    logic     ce_pix;
    hcount_t  h_count;
    vcount_t  v_count;
    byte_t    video_data;
    logic     shr_enable;
    pal_idx_t border_color;
    vaddr_t   video_addr;
    byte_t    r;
    byte_t    g;
    byte_t    b;
    logic     scanline_irq;
    logic     vbl_irq;

    byte_t    mem [vaddr_t];  // Sparse video memory where holes read as 0
    int       cycles = 0;
    int       last_line;      // Previous line of this test (-1 if none yet)
    logic     en_cfg;         // shr_enable from slot 0 of the next line
    pal_idx_t border_cfg;     // border_color from slot 0 of the next line
    rgb12_t   exp_rgb [912];  // Expected colour per slot of the line
    logic     exp_ok [912];   // Colour known for that slot

    tb_clock i_clock (
        .clk_vid (clk_vid),
        .reset   (reset)
    );

    vgc_top i_dut (
        .clk_vid      (clk_vid),
        .reset        (reset),
        .ce_pix       (ce_pix),
        .h_count      (h_count),
        .v_count      (v_count),
        .video_data   (video_data),
        .shr_enable   (shr_enable),
        .border_color (border_color),
        .video_addr   (video_addr),
        .r            (r),
        .g            (g),
        .b            (b),
        .scanline_irq (scanline_irq),
        .vbl_irq      (vbl_irq)
    );

    // Address is a register, so data trails it by one slot
    always_comb video_data = rd_byte(video_addr);

    always @(posedge clk_vid) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d clock cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $fatal(1, "Run stopped at the cycle limit");
        end
    end

    function automatic byte_t rd_byte(vaddr_t a);
        if ($isunknown(a) || !mem.exists(a)) return 8'h00;
        return mem[a];
    endfunction

    function automatic byte_t rand_pal();
        return byte_t'($urandom_range(15, 0));
    endfunction

    // 640 mode index of one slot through its own sub-palette
    function automatic pal_idx_t idx_640(byte_t d, logic [1:0] slot);
        case (slot)
            2'd0:    return {2'd2, d[7:6]};
            2'd1:    return {2'd3, d[5:4]};
            2'd2:    return {2'd0, d[3:2]};
            default: return {2'd1, d[1:0]};
        endcase
    endfunction

    function automatic rgb12_t pal_color(byte_t scb, pal_idx_t idx);
        vaddr_t a;
        byte_t  gb;
        byte_t  rr;
        a  = SHR_PAL_BASE + vaddr_t'(scb[3:0]) * SHR_PAL_STRIDE + vaddr_t'(idx) * 2;
        gb = rd_byte(a);      // Green high, blue low
        rr = rd_byte(a + 1);  // Red in the low nibble
        return {rr[3:0], gb};
    endfunction

    task automatic check(string name, logic [31:0] act, logic [31:0] exp);
        if (act !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h (line %0d, slot %0d)",
                     name, act, exp, v_count, h_count);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic wr_byte(vaddr_t a, byte_t d);
        mem[a] = d;
    endtask

    task automatic load_palettes();
        int i;
        for (i = 0; i < 16 * PAL_BYTES; i++) begin
            wr_byte(SHR_PAL_BASE + vaddr_t'(i), byte_t'($urandom));
        end
    endtask

    // SCB and 160 pixel bytes of one row (sparse gives many zero nibbles)
    task automatic load_row(int row, byte_t scb, logic sparse);
        int    j;
        byte_t d;
        wr_byte(SHR_SCB_BASE + vaddr_t'(row), scb);
        for (j = 0; j < SHR_ROW_BYTES; j++) begin
            d = byte_t'($urandom);
            if (sparse) d = d & byte_t'($urandom);
            wr_byte(SHR_PIXEL_BASE + vaddr_t'(row * SHR_ROW_BYTES + j), d);
        end
    endtask

    // Expected colour of every slot of line v
    task automatic build_expected(vcount_t v, logic full, byte_t scb);
        vaddr_t   row_base;
        byte_t    d;
        nibble_t  nib;
        pal_idx_t idx;
        pal_idx_t last_nz;
        logic     win_line;
        int       s;
        row_base = SHR_PIXEL_BASE + vaddr_t'(vcount_t'(v - V_ACTIVE_START)) * SHR_ROW_BYTES;
        win_line = en_cfg && (v >= V_ACTIVE_START) && (v < V_ACTIVE_START + V_ACTIVE_LINES);
        last_nz  = '0;  // Fill starts from entry 0 at the left edge
        for (s = 0; s < int'(H_TOTAL); s++) begin
            exp_rgb[s] = BORDER_PALETTE[border_cfg];
            exp_ok[s]  = 1'b1;
            if (win_line && (s >= COL_FIRST) && (s < COL_END)) begin
                d   = rd_byte(row_base + vaddr_t'((s - COL_FIRST) / 4));
                nib = s[1] ? d[3:0] : d[7:4];  // 320 pixel spans two slots
                if (scb[SCB_BIT_640]) begin
                    idx = idx_640(d, 2'(s));
                end else if (scb[SCB_BIT_FILL] && (nib == 4'd0)) begin
                    idx = last_nz;
                end else begin
                    idx = nib;
                end
                if (nib != 4'd0) last_nz = nib;
                exp_rgb[s] = pal_color(scb, idx);
                exp_ok[s]  = full;  // Palette only known after the line before
            end
        end
    endtask

    // Runs slots 0..911 of line v and checks every slot at the falling edge
    task automatic run_line(vcount_t v);
        vcount_t row_n;
        byte_t   scb_n;
        byte_t   scb_c;
        logic    full;
        logic    act_line;
        logic    irq_exp;
        vaddr_t  pal_n;
        vaddr_t  pal_c;
        vaddr_t  pix_c;
        int      h;
        full     = (last_line == int'(v) - 1);
        row_n    = v + 9'd1 - V_ACTIVE_START;  // Row fetched for the next line
        scb_n    = rd_byte(SHR_SCB_BASE + vaddr_t'(row_n));
        scb_c    = rd_byte(SHR_SCB_BASE + vaddr_t'(vcount_t'(v - V_ACTIVE_START)));
        act_line = (v >= V_ACTIVE_START) && (v < V_ACTIVE_START + V_ACTIVE_LINES);
        irq_exp  = scb_n[SCB_BIT_IRQ] && en_cfg && (row_n < V_ACTIVE_LINES);
        pal_n    = SHR_PAL_BASE + vaddr_t'(scb_n[3:0]) * SHR_PAL_STRIDE;
        pal_c    = SHR_PAL_BASE + vaddr_t'(scb_c[3:0]) * SHR_PAL_STRIDE;
        pix_c    = SHR_PIXEL_BASE + vaddr_t'(vcount_t'(v - V_ACTIVE_START)) * SHR_ROW_BYTES;
        build_expected(v, full, scb_c);
        for (h = 0; h < int'(H_TOTAL); h++) begin
            @(posedge clk_vid);
            h_count <= hcount_t'(h);
            v_count <= v;
            if (h == 0) begin
                shr_enable   <= en_cfg;
                border_color <= border_cfg;
            end
            @(negedge clk_vid);
            // Address seen in slot h was presented after slot h-1
            if (h == int'(H_SCB_ADDR) + 1) begin
                check("video_addr", video_addr, SHR_SCB_BASE + vaddr_t'(row_n));
            end else if (h >= int'(H_SCB_ADDR) + 2) begin
                check("video_addr", video_addr, pal_n + vaddr_t'(h - 902));
            end else if ((h <= 21) && full) begin
                check("video_addr", video_addr, pal_c + vaddr_t'(h + 10));  // Burst wraps
            end else if (act_line && (h >= COL_FIRST) && (h < COL_END)) begin
                check("video_addr", video_addr, pix_c + vaddr_t'((h - COL_FIRST) / 4));
            end
            check("scanline_irq", scanline_irq, (h == 902) && irq_exp);
            if (h >= 1) check("vbl_irq", vbl_irq, v == V_VBL_LINE);
            if ((h >= 2) && exp_ok[h - 2]) begin  // Two slots from data to RGB
                check("r", r, {2{exp_rgb[h - 2][11:8]}});
                check("g", g, {2{exp_rgb[h - 2][7:4]}});
                check("b", b, {2{exp_rgb[h - 2][3:0]}});
            end
        end
        last_line = int'(v);
    endtask

    task automatic reset_values();
        @(negedge clk_vid);  // Still inside the reset pulse
        check("r", r, 0);
        check("g", g, 0);
        check("b", b, 0);
        check("scanline_irq", scanline_irq, 0);
        check("vbl_irq", vbl_irq, 0);
        check("video_addr", video_addr, 0);
        wait (reset == 1'b0);
    endtask

    // Rows 0 and 1 in 640 mode with an interrupt from row 0
    task automatic rows_640();
        last_line = -1;
        load_palettes();
        load_row(0, 8'hC0 | rand_pal(), 1'b0);
        load_row(1, 8'h80 | rand_pal(), 1'b0);
        run_line(15);
        run_line(16);
        run_line(17);
    endtask

    // Row 34 in plain 320 and row 35 with fill
    task automatic rows_320_fill();
        last_line = -1;
        load_palettes();
        load_row(34, rand_pal(), 1'b1);
        load_row(35, 8'h60 | rand_pal(), 1'b1);
        run_line(49);
        run_line(50);
        run_line(51);
    endtask

    // Top border lines, then SHR off over rows that ask for interrupts
    task automatic border_and_off();
        last_line  = -1;
        border_cfg = pal_idx_t'($urandom_range(15, 1));
        load_row(84, 8'hC0 | rand_pal(), 1'b0);
        load_row(85, 8'h40 | rand_pal(), 1'b1);
        run_line(5);
        run_line(6);
        en_cfg = 1'b0;
        run_line(99);
        run_line(100);
        en_cfg = 1'b1;
    endtask

    // Rows 198 and 199 then VBL with the interrupt from row 199 only
    task automatic irq_and_vbl();
        last_line = -1;
        load_row(198, 8'h80 | rand_pal(), 1'b0);
        load_row(199, 8'h40 | rand_pal(), 1'b1);
        wr_byte(SHR_SCB_BASE + 23'd200, 8'hC0);
        run_line(213);
        run_line(214);
        run_line(215);
        run_line(216);
        run_line(217);
    endtask

    initial begin
        void'($urandom(5832));
        ce_pix       = 1'b1;  // Every clock is a pixel slot
        h_count      = '0;
        v_count      = '0;
        shr_enable   = 1'b1;
        border_color = '0;
        en_cfg       = 1'b1;
        border_cfg   = '0;
        last_line    = -1;
        reset_values();
        rows_640();
        rows_320_fill();
        border_and_off();
        irq_and_vbl();
        $display("TEST OK");
        $finish;
    end

endmodule

/* all.f */
source/vgc_pkg.sv
source/shr_fetch.sv
source/shr_palette.sv
source/shr_pixel_decode.sv
source/vid_output.sv
source/vgc_top.sv
test/tb_clock.sv
test/tb_vgc.sv
